// File: orange_cam.f
+incdir+tests
design/cam_pkg.sv
design/cam_capture.sv
design/frame_buffer.sv
design/scan_timing.sv
design/target_finder.sv
design/classification.sv
design/cam_top.sv
tests/cam_tb.sv

// File: tests/cam_tb_model.svh
`ifndef CAM_TB_MODEL_SVH
`define CAM_TB_MODEL_SVH

// 4-bit channel to 8 bits, n * 17 is the nibble written twice
function automatic rgb888_t widen_pixel(pix444_t p);
  rgb888_t w;
  w.r = 8'(p.r * 17);
  w.g = 8'(p.g * 17);
  w.b = 8'(p.b * 17);
  return w;
endfunction

// orange window on the widened colour, bounds inclusive
function automatic bit meets_orange_rule(pix444_t p);
  rgb888_t w;
  w = widen_pixel(p);
  return (w.r >= ORANGE_R_MIN) && (w.g >= ORANGE_G_MIN) &&
         (w.g <= ORANGE_G_MAX) && (w.b <= ORANGE_B_MAX);
endfunction

// colour expected on the pins for a stored pixel inside the picture
function automatic rgb888_t display_color(pix444_t p);
  return meets_orange_rule(p) ? MARK_COLOR : widen_pixel(p);
endfunction

// bin orange pixels by column third, then pick a direction
// ties go to centre first, then left
function automatic dir_t steer_for_frame(pix444_t f [PIXELS]);
  int l;
  int c;
  int r;
  l = 0;
  c = 0;
  r = 0;
  for (int i = 0; i < PIXELS; i++) begin
    if (meets_orange_rule(f[i])) begin
      if ((i % FRAME_W) < THIRD_1) l++;
      else if ((i % FRAME_W) < THIRD_2) c++;
      else r++;
    end
  end
  if (l + c + r < MIN_COUNT) return DIR_NONE;
  if ((c >= l) && (c >= r)) return DIR_CENTER;
  if (l >= r) return DIR_LEFT;
  return DIR_RIGHT;
endfunction

`endif

// File: tests/cam_tb.sv
`timescale 1ns/1ps

module cam_tb;

  import cam_pkg::*;

  `include "cam_tb_model.svh"

  // frame kinds: mixed, left, centre, right, no target
  localparam int N_TESTS     = 5;
  localparam int CYCLE_LIMIT = N_TESTS * 4 * H_TOTAL * V_TOTAL + 10;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       cam_vsync;
  logic       cam_href;
  logic [7:0] cam_data;
  rgb888_t    vga_rgb;
  logic       vga_hsync_n;
  logic       vga_vsync_n;
  logic       vga_active;
  dir_t       direction;
  logic       orange_detected;

  // copy of the frame sent to the camera port
  pix444_t frame [PIXELS];
  dir_t    exp_dir;
  int      err_cnt = 0;
  int      cycles = 0;
  string   kind_name [5] = '{"mixed", "left", "centre", "right", "none"};

  cam_top dut_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .cam_vsync       (cam_vsync),
    .cam_href        (cam_href),
    .cam_data        (cam_data),
    .vga_rgb         (vga_rgb),
    .vga_hsync_n     (vga_hsync_n),
    .vga_vsync_n     (vga_vsync_n),
    .vga_active      (vga_active),
    .direction       (direction),
    .orange_detected (orange_detected)
  );

  always #4 clk = ~clk;

  // run limit, four display frames per test is ample
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run still going after %0d clocks", CYCLE_LIMIT);
      $display("Test failures found");
      $finish;
    end
  end

  task automatic check_rgb(string name, rgb888_t got, rgb888_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_dir(string name, dir_t got, dir_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  // orange values stay inside the window, others are redrawn until outside
  function automatic pix444_t draw_pixel(bit want_orange);
    pix444_t p;
    if (want_orange) begin
      p.r = 4'($urandom_range(15, 12));
      p.g = 4'($urandom_range(9, 4));
      p.b = 4'($urandom_range(4, 0));
    end else begin
      do p = 12'($urandom); while (meets_orange_rule(p));
    end
    return p;
  endfunction

  // kind 1..3 favours the matching third, kind 4 keeps the count under MIN_COUNT
  task automatic build_frame(int kind);
    int  n_orange;
    int  third;
    bit  want;
    n_orange = 0;
    for (int i = 0; i < PIXELS; i++) begin
      third = ((i % FRAME_W) < THIRD_1) ? 1 : ((i % FRAME_W) < THIRD_2) ? 2 : 3;
      case (kind)
        0: want = ($urandom_range(3, 0) == 0);
        1, 2, 3: want = (third == kind) ? ($urandom_range(1, 0) == 0) :
                                          ($urandom_range(15, 0) == 0);
        default: want = (n_orange < MIN_COUNT - 1) && ($urandom_range(63, 0) == 0);
      endcase
      if (want) n_orange++;
      frame[i] = draw_pixel(want);
    end
    exp_dir = steer_for_frame(frame);
  endtask

  // camera vsync, then 24 href lines of byte pairs with short gaps
  task automatic send_frame();
    cam_vsync = 1'b1;
    repeat (3) @(negedge clk);
    cam_vsync = 1'b0;
    for (int y = 0; y < FRAME_H; y++) begin
      repeat (6) @(negedge clk);
      for (int x = 0; x < FRAME_W; x++) begin
        cam_href = 1'b1;
        // upper nibble of the red byte carries junk
        cam_data = {4'($urandom), frame[y * FRAME_W + x].r};
        @(negedge clk);
        cam_data = {frame[y * FRAME_W + x].g, frame[y * FRAME_W + x].b};
        @(negedge clk);
      end
      cam_href = 1'b0;
    end
  endtask

  task automatic wait_vsync_fall();
    logic prev;
    prev = vga_vsync_n;
    @(negedge clk);
    while (!(prev && !vga_vsync_n)) begin
      prev = vga_vsync_n;
      @(negedge clk);
    end
  endtask

  // entered on the fall, returns on the next one
  task automatic check_display_frame();
    logic prev;
    bit   done;
    int   clocks;
    int   idx;
    int   hs_low;
    int   vs_low;
    prev   = 1'b0;
    done   = 1'b0;
    clocks = 0;
    idx    = 0;
    hs_low = 0;
    vs_low = 0;
    while (!done) begin
      @(negedge clk);
      clocks++;
      // one full scan period holds every sync pulse exactly once per line or frame
      if (!vga_hsync_n) begin
        hs_low++;
      end
      if (!vga_vsync_n) begin
        vs_low++;
      end
      if (prev && !vga_vsync_n) begin
        done = 1'b1;
      end else if (vga_active) begin
        // active pixels leave in raster order
        if (idx < PIXELS) begin
          check_rgb($sformatf("vga_rgb[%0d]", idx), vga_rgb, display_color(frame[idx]));
        end
        idx++;
      end else begin
        check_rgb("vga_rgb (blank)", vga_rgb, '0);
      end
      prev = vga_vsync_n;
    end
    check_count("frame clocks", clocks, H_TOTAL * V_TOTAL);
    check_count("active clocks", idx, PIXELS);
    check_count("vga_hsync_n low clocks", hs_low, V_TOTAL * H_SYNC_LEN);
    check_count("vga_vsync_n low clocks", vs_low, H_TOTAL * V_SYNC_LEN);
  endtask

  initial begin
    int errs_before;
    int n_fail;
    rst_n     = 1'b0;
    cam_vsync = 1'b0;
    cam_href  = 1'b0;
    cam_data  = 8'h00;
    n_fail    = 0;
    void'($urandom(16345));
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    // idle outputs before any camera data
    check_bit("vga_hsync_n", vga_hsync_n, 1'b1);
    check_bit("vga_vsync_n", vga_vsync_n, 1'b1);
    check_bit("vga_active", vga_active, 1'b0);
    check_rgb("vga_rgb", vga_rgb, '0);
    check_dir("direction", direction, DIR_NONE);
    check_bit("orange_detected", orange_detected, 1'b0);
    if (err_cnt != 0) n_fail++;
    $display("test reset: %s", (err_cnt == 0) ? "pass" : "fail");
    for (int t = 0; t < N_TESTS; t++) begin
      errs_before = err_cnt;
      build_frame(t % 5);
      send_frame();
      // buffer is stable for the whole frame after this fall
      wait_vsync_fall();
      check_display_frame();
      // result lands one clock after the fall
      @(negedge clk);
      check_dir("direction", direction, exp_dir);
      check_bit("orange_detected", orange_detected, exp_dir != DIR_NONE);
      if (err_cnt != errs_before) n_fail++;
      $display("test %0d %s: %s", t, kind_name[t % 5],
               (err_cnt == errs_before) ? "pass" : "fail");
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             N_TESTS + 1, N_TESTS + 1 - n_fail, n_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: design/cam_top.sv
`timescale 1ns/1ps

module cam_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cam_vsync,
  input  logic              cam_href,
  input  logic [7:0]        cam_data,
  output cam_pkg::rgb888_t  vga_rgb,
  output logic              vga_hsync_n,
  output logic              vga_vsync_n,
  output logic              vga_active,
  output cam_pkg::dir_t     direction,
  output logic              orange_detected
);

  import cam_pkg::*;

  // camera side writes
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  pix444_t           wr_pix;
  // display side reads and pipeline
  logic [ADDR_W-1:0] rd_addr;
  video_ctl_t        scan_ctl;
  pix444_t           rd_pix;
  video_ctl_t        pix_ctl;
  video_ctl_t        vga_ctl;
  logic              is_orange;

  cam_capture u_capture (
    .clk       (clk),
    .rst_n     (rst_n),
    .cam_vsync (cam_vsync),
    .cam_href  (cam_href),
    .cam_data  (cam_data),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_pix    (wr_pix)
  );

  frame_buffer u_frame_buffer (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_pix   (wr_pix),
    .rd_addr  (rd_addr),
    .scan_ctl (scan_ctl),
    .rd_pix   (rd_pix),
    .pix_ctl  (pix_ctl)
  );

  scan_timing u_scan (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_addr  (rd_addr),
    .scan_ctl (scan_ctl)
  );

  target_finder u_finder (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_pix    (rd_pix),
    .pix_ctl   (pix_ctl),
    .vga_rgb   (vga_rgb),
    .vga_ctl   (vga_ctl),
    .is_orange (is_orange)
  );

  classification u_classifier (
    .clk             (clk),
    .rst_n           (rst_n),
    .is_orange       (is_orange),
    .vga_ctl         (vga_ctl),
    .direction       (direction),
    .orange_detected (orange_detected)
  );

  // vga pins straight from the finder output stage
  assign vga_hsync_n = vga_ctl.hsync_n;
  assign vga_vsync_n = vga_ctl.vsync_n;
  assign vga_active  = vga_ctl.active;

endmodule

// File: design/classification.sv
`timescale 1ns/1ps

module classification (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 is_orange,
  input  cam_pkg::video_ctl_t  vga_ctl,
  output cam_pkg::dir_t        direction,
  output logic                 orange_detected
);

  import cam_pkg::*;

  // orange pixel counts per column third
  logic [CNT_W-1:0] cnt_l;
  logic [CNT_W-1:0] cnt_c;
  logic [CNT_W-1:0] cnt_r;
  logic [CNT_W+1:0] total;
  // previous vsync level for edge detection
  logic             vsync_q;
  logic             frame_end;

  assign total = (CNT_W + 2)'(cnt_l) + (CNT_W + 2)'(cnt_c) + (CNT_W + 2)'(cnt_r);

  // falling vsync closes the frame just shown
  assign frame_end = vsync_q && !vga_ctl.vsync_n;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vsync_q         <= 1'b1;
      cnt_l           <= '0;
      cnt_c           <= '0;
      cnt_r           <= '0;
      direction       <= DIR_NONE;
      orange_detected <= 1'b0;
    end else begin
      vsync_q <= vga_ctl.vsync_n;
      if (frame_end) begin
        // decide on the finished frame, then start over
        if (total < (CNT_W + 2)'(MIN_COUNT)) begin
          direction       <= DIR_NONE;
          orange_detected <= 1'b0;
        end else begin
          orange_detected <= 1'b1;
          // centre wins ties, then left over right
          if ((cnt_c >= cnt_l) && (cnt_c >= cnt_r)) begin
            direction <= DIR_CENTER;
          end else if (cnt_l >= cnt_r) begin
            direction <= DIR_LEFT;
          end else begin
            direction <= DIR_RIGHT;
          end
        end
        cnt_l <= '0;
        cnt_c <= '0;
        cnt_r <= '0;
      end else if (is_orange) begin
        // bin by column
        if (vga_ctl.x < 5'(THIRD_1)) begin
          cnt_l <= cnt_l + 1'b1;
        end else if (vga_ctl.x < 5'(THIRD_2)) begin
          cnt_c <= cnt_c + 1'b1;
        end else begin
          cnt_r <= cnt_r + 1'b1;
        end
      end
    end
  end

  // the flag and the direction never disagree about a target
  a_dir_flag: assert property (@(posedge clk) disable iff (!rst_n)
    (direction == DIR_NONE) == !orange_detected)
    else $error("direction and orange_detected disagree");

endmodule

// File: design/target_finder.sv
`timescale 1ns/1ps

module target_finder (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cam_pkg::pix444_t     rd_pix,
  input  cam_pkg::video_ctl_t  pix_ctl,
  output cam_pkg::rgb888_t     vga_rgb,
  output cam_pkg::video_ctl_t  vga_ctl,
  output logic                 is_orange
);

  import cam_pkg::*;

  rgb888_t expanded;
  logic    orange;

  // nibble repeat so 0xF maps to 0xFF and 0x0 to 0x00
  assign expanded = '{r: {rd_pix.r, rd_pix.r},
                      g: {rd_pix.g, rd_pix.g},
                      b: {rd_pix.b, rd_pix.b}};

  // strong red, moderate green, little blue
  assign orange = (expanded.r >= ORANGE_R_MIN) &&
                  (expanded.g >= ORANGE_G_MIN) &&
                  (expanded.g <= ORANGE_G_MAX) &&
                  (expanded.b <= ORANGE_B_MAX);

  // output stage toward the vga pins
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vga_rgb   <= '0;
      vga_ctl   <= CTL_IDLE;
      is_orange <= 1'b0;
    end else begin
      vga_ctl   <= pix_ctl;
      // blanking pixels never count as targets
      is_orange <= pix_ctl.active && orange;
      if (!pix_ctl.active) begin
        vga_rgb <= '0;
      end else if (orange) begin
        vga_rgb <= MARK_COLOR;
      end else begin
        vga_rgb <= expanded;
      end
    end
  end

endmodule

// File: design/scan_timing.sv
`timescale 1ns/1ps

module scan_timing (
  input  logic                        clk,
  input  logic                        rst_n,
  output logic [cam_pkg::ADDR_W-1:0]  rd_addr,
  output cam_pkg::video_ctl_t         scan_ctl
);

  import cam_pkg::*;

  // column and line position inside the scan period
  logic [H_CNT_W-1:0] h_cnt;
  logic [V_CNT_W-1:0] v_cnt;
  logic               active;

  // line and frame counters
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // start in vertical blanking so the first frame opens cleanly
      h_cnt <= '0;
      v_cnt <= V_CNT_W'(FRAME_H);
    end else if (h_cnt == H_CNT_W'(H_TOTAL - 1)) begin
      h_cnt <= '0;
      if (v_cnt == V_CNT_W'(V_TOTAL - 1)) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + 1'b1;
      end
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // visible picture in the top left corner of the scan
  assign active = (h_cnt < H_CNT_W'(FRAME_W)) && (v_cnt < V_CNT_W'(FRAME_H));

  always_comb begin
    scan_ctl.hsync_n = !((h_cnt >= H_CNT_W'(H_SYNC_START)) &&
                         (h_cnt <  H_CNT_W'(H_SYNC_START + H_SYNC_LEN)));
    scan_ctl.vsync_n = !((v_cnt >= V_CNT_W'(V_SYNC_START)) &&
                         (v_cnt <  V_CNT_W'(V_SYNC_START + V_SYNC_LEN)));
    scan_ctl.active  = active;
    // column index used by the classifier
    scan_ctl.x       = active ? 5'(h_cnt) : 5'd0;
  end

  // raster address, parked at zero in blanking
  assign rd_addr = active ? (ADDR_W'(v_cnt) * ADDR_W'(FRAME_W) + ADDR_W'(h_cnt)) : '0;

  // sync pulses must sit entirely in blanking
  a_sync_in_blank: assert property (@(posedge clk) disable iff (!rst_n)
    scan_ctl.active |-> (scan_ctl.hsync_n && scan_ctl.vsync_n))
    else $error("sync pulse inside active area");

endmodule

// File: design/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        wr_en,
  input  logic [cam_pkg::ADDR_W-1:0]  wr_addr,
  input  cam_pkg::pix444_t            wr_pix,
  input  logic [cam_pkg::ADDR_W-1:0]  rd_addr,
  input  cam_pkg::video_ctl_t         scan_ctl,
  output cam_pkg::pix444_t            rd_pix,
  output cam_pkg::video_ctl_t         pix_ctl
);

  import cam_pkg::*;

  // one stored pixel per display position
  pix444_t mem [PIXELS];

  // write port from the camera, read port for the display
  // a same-address collision reads the previous contents
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_pix;
    end
    rd_pix <= mem[rd_addr];
  end

  // scan state delayed to line up with the read data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pix_ctl <= CTL_IDLE;
    end else begin
      pix_ctl <= scan_ctl;
    end
  end

endmodule

// File: design/cam_capture.sv
`timescale 1ns/1ps

module cam_capture (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        cam_vsync,
  input  logic                        cam_href,
  input  logic [7:0]                  cam_data,
  output logic                        wr_en,
  output logic [cam_pkg::ADDR_W-1:0]  wr_addr,
  output cam_pkg::pix444_t            wr_pix
);

  import cam_pkg::*;

  // low on the red byte, high on the green/blue byte
  logic              byte_phase;
  // red nibble waiting for its partner byte
  logic [3:0]        red_hold;
  // next free buffer location, stops at PIXELS
  logic [ADDR_W-1:0] addr_cnt;

  // control path
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      byte_phase <= 1'b0;
      addr_cnt   <= '0;
      wr_en      <= 1'b0;
    end else begin
      // default is no write, wr_en is a single-cycle strobe
      wr_en <= 1'b0;
      if (cam_vsync) begin
        // new frame from the sensor
        byte_phase <= 1'b0;
        addr_cnt   <= '0;
      end else if (cam_href) begin
        byte_phase <= ~byte_phase;
        // second byte of a pair completes the pixel
        if (byte_phase && (addr_cnt < ADDR_W'(PIXELS))) begin
          wr_en    <= 1'b1;
          addr_cnt <= addr_cnt + 1'b1;
        end
      end else begin
        // each line starts on a red byte
        byte_phase <= 1'b0;
      end
    end
  end

  // pixel payload
  always_ff @(posedge clk) begin
    if (cam_href && !byte_phase) begin
      red_hold <= cam_data[3:0];
    end
    if (cam_href && byte_phase) begin
      wr_addr <= addr_cnt;
      wr_pix  <= '{r: red_hold, g: cam_data[7:4], b: cam_data[3:0]};
    end
  end

  // data past the end of the buffer must never reach the memory
  a_wr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> (wr_addr < ADDR_W'(PIXELS)))
    else $error("frame buffer write out of range");

endmodule

// File: design/cam_pkg.sv
package cam_pkg;

  // active picture, kept tiny for short simulations
  localparam int FRAME_W = 32;
  localparam int FRAME_H = 24;
  localparam int PIXELS  = FRAME_W * FRAME_H;
  localparam int ADDR_W  = 10;

  // scan period in clocks per line and lines per frame
  localparam int H_TOTAL = 40;
  localparam int V_TOTAL = 28;
  localparam int H_CNT_W = $clog2(H_TOTAL);
  localparam int V_CNT_W = $clog2(V_TOTAL);

  // sync pulse placement, both active low
  localparam int H_SYNC_START = 34;
  localparam int H_SYNC_LEN   = 2;
  localparam int V_SYNC_START = 25;
  localparam int V_SYNC_LEN   = 1;

  // first column of the centre third and of the right third
  localparam int THIRD_1 = 11;
  localparam int THIRD_2 = 22;

  // orange window on the expanded 8-bit channels
  localparam logic [7:0] ORANGE_R_MIN = 8'hC0;
  localparam logic [7:0] ORANGE_G_MIN = 8'h40;
  localparam logic [7:0] ORANGE_G_MAX = 8'hA0;
  localparam logic [7:0] ORANGE_B_MAX = 8'h50;

  // fewest orange pixels per frame that count as a target
  localparam int MIN_COUNT = 8;
  localparam int CNT_W     = 10;

  // camera pixel as stored in the frame buffer
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } pix444_t;

  // colour on the vga pins
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb888_t;

  // magenta overlay for marked pixels
  localparam rgb888_t MARK_COLOR = '{r: 8'hFF, g: 8'h00, b: 8'hFF};

  // scan state that rides along with each pixel
  typedef struct packed {
    logic       hsync_n;
    logic       vsync_n;
    logic       active;
    logic [4:0] x;
  } video_ctl_t;

  // blanked, no sync pulse
  localparam video_ctl_t CTL_IDLE = '{hsync_n: 1'b1, vsync_n: 1'b1, active: 1'b0, x: 5'd0};

  typedef enum logic [1:0] {
    DIR_NONE,
    DIR_LEFT,
    DIR_CENTER,
    DIR_RIGHT
  } dir_t;

endpackage
